//--- i2c_byte_shifter.sv
`default_nettype none

module i2c_byte_shifter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [i2c_pkg::ADDR_W-1:0] slave_addr,
    input  logic                       rw_bit,
    input  logic [i2c_pkg::DATA_W-1:0] tx_data,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    i2c_shift_if.shifter               sh
);

    logic [i2c_pkg::DATA_W-1:0]    addr_byte;  // {address, R/W}
    logic [i2c_pkg::DATA_W-1:0]    data_byte;
    logic                          sel_data;   // Data byte on the wire
    logic [i2c_pkg::BIT_CNT_W-1:0] idx;        // Bits already sent
    logic [i2c_pkg::BIT_CNT_W-1:0] pos;

    // Bit position 7 - idx
    assign pos = ~idx;

    assign sh.tx_bit   = sel_data ? data_byte[pos] : addr_byte[pos];
    assign sh.last_bit = &idx;
    assign sh.is_read  = addr_byte[0];

    // Transaction payload, held until the next load
    always_ff @(posedge clk) begin
        if (sh.load) begin
            addr_byte <= {slave_addr, rw_bit};
            data_byte <= tx_data;
        end
    end

    // Byte select and bit index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_data <= 1'b0;
            idx      <= '0;
        end else if (sh.load) begin
            sel_data <= 1'b0;
            idx      <= '0;
        end else if (sh.next_byte) begin
            sel_data <= 1'b1;
            idx      <= '0;
        end else if (sh.advance) begin
            idx <= idx + 1'b1;
        end
    end

    // Received byte, filled MSB first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_data <= '0;
        end else if (sh.load) begin
            rx_data <= '0;
        end else if (sh.capture) begin
            rx_data[pos] <= sh.capture_val;
        end
    end

    a_no_advance_on_load : assert property (
        @(posedge clk) disable iff (!rst_n)
        sh.load |-> !sh.advance
    );

endmodule

`default_nettype wire

//--- i2c_master.sv
`default_nettype none

module i2c_master (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,       // One-clock pulse
    input  logic                       rw_bit,
    input  logic [i2c_pkg::ADDR_W-1:0] slave_addr,
    input  logic [i2c_pkg::DATA_W-1:0] tx_data,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    output logic                       busy,
    output logic                       done,        // One-clock pulse
    output logic                       ack_error,
    inout  wire                        sda,
    output logic                       scl
);

    logic sda_out;
    logic sda_oe;
    wire  sda_in;

    i2c_tick_if  tk ();
    i2c_shift_if sh ();

    // ======================================================================
    // SDA pad
    // ======================================================================
    assign sda    = sda_oe ? sda_out : 1'bz;
    assign sda_in = sda;

    i2c_phase_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tk    (tk.timer)
    );

    i2c_byte_shifter u_shifter (
        .clk        (clk),
        .rst_n      (rst_n),
        .slave_addr (slave_addr),
        .rw_bit     (rw_bit),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .sh         (sh.shifter)
    );

    i2c_txn_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .tk        (tk.seq),
        .sh        (sh.seq)
    );

endmodule

`default_nettype wire

//--- i2c_phase_timer.sv
`default_nettype none

module i2c_phase_timer (
    input  logic       clk,
    input  logic       rst_n,
    i2c_tick_if.timer  tk
);

    logic [i2c_pkg::PHASE_CNT_W-1:0] cnt;    // Clocks into current phase
    i2c_pkg::scl_phase_t             phase;

    assign tk.phase = phase;

    // Counter sits at 0 while stopped, so neither strobe can fire then
    assign tk.tick   = (int'(cnt) == i2c_pkg::CLK_PER_PHASE - 1);
    assign tk.sample = (phase == i2c_pkg::high_1) &&
                       (int'(cnt) == i2c_pkg::SAMPLE_POINT);

    // ======================================================================
    // Clock divider and phase sequence
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            phase <= i2c_pkg::low_1;
        end else if (!tk.run) begin
            cnt   <= '0;
            phase <= i2c_pkg::low_1;
        end else if (tk.tick) begin
            cnt <= '0;
            if (tk.phase_clr) begin
                phase <= i2c_pkg::low_1;  // START/STOP steps keep bits aligned
            end else begin
                phase <= i2c_pkg::scl_phase_t'(phase + 2'd1);  // high_2 wraps to low_1
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // A dropped run has to leave the divider quiet on the following clocks too
    a_quiet_when_stopped : assert property (
        @(posedge clk) disable iff (!rst_n)
        !tk.run |-> !(tk.tick || tk.sample)
    );

endmodule

`default_nettype wire

//--- i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // ======================================================================
    // Bus timing, 100 MHz system clock to 100 kHz SCL
    // ======================================================================
    localparam int CLK_PER_PHASE   = 250;                // Quarter of one SCL bit
    localparam int PHASE_CNT_W     = 8;
    localparam int PHASES_PER_COND = 2;                  // Each START/STOP step
    localparam int SAMPLE_POINT    = CLK_PER_PHASE / 2;  // Middle of high_1

    // Field widths
    localparam int ADDR_W    = 7;
    localparam int DATA_W    = 8;
    localparam int BIT_CNT_W = 3;

    // R/W bit in the address byte
    localparam logic I2C_WRITE = 1'b0;
    localparam logic I2C_READ  = 1'b1;

    // ======================================================================
    // Phases of one SCL bit and transaction states
    // ======================================================================
    typedef enum logic [1:0] {
        low_1,
        low_2,
        high_1,
        high_2
    } scl_phase_t;

    typedef enum logic [3:0] {
        idle,
        start_1,    // SCL high, SDA high
        start_2,    // SDA falls
        start_3,    // SCL falls
        addr_bit,
        addr_ack,
        data_bit,
        data_ack,
        stop_1,     // SCL low, SDA low
        stop_2,     // SCL rises
        stop_3      // SDA rises
    } txn_state_t;

endpackage

`default_nettype wire

//--- i2c_shift_if.sv
`default_nettype none

interface i2c_shift_if;
    // Commands, one-clock pulses from the sequencer
    logic load;         // Latch addr, R/W and tx data
    logic next_byte;    // Switch to the data byte
    logic advance;      // Next bit
    logic capture;      // Store capture_val at current bit
    logic capture_val;

    // Status back to the sequencer
    logic tx_bit;       // Current bit, MSB first
    logic last_bit;     // Bit index is 7
    logic is_read;      // Latched R/W bit

    modport shifter (
        input  load,
        input  next_byte,
        input  advance,
        input  capture,
        input  capture_val,
        output tx_bit,
        output last_bit,
        output is_read
    );

    modport seq (
        output load,
        output next_byte,
        output advance,
        output capture,
        output capture_val,
        input  tx_bit,
        input  last_bit,
        input  is_read
    );
endinterface

`default_nettype wire

//--- i2c_tick_if.sv
`default_nettype none

interface i2c_tick_if;
    logic                run;        // Timer counts while high
    logic                phase_clr;  // Each tick returns phase to low_1
    i2c_pkg::scl_phase_t phase;
    logic                tick;       // Last clock of a phase
    logic                sample;     // SDA sample point inside high_1

    // Phase timer side
    modport timer (
        input  run,
        input  phase_clr,
        output phase,
        output tick,
        output sample
    );

    // Sequencer side
    modport seq (
        output run,
        output phase_clr,
        input  phase,
        input  tick,
        input  sample
    );
endinterface

`default_nettype wire

//--- i2c_txn_fsm.sv
`default_nettype none

module i2c_txn_fsm (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_oe,
    output logic      busy,
    output logic      done,
    output logic      ack_error,
    i2c_tick_if.seq   tk,
    i2c_shift_if.seq  sh
);

    i2c_pkg::txn_state_t state;
    i2c_pkg::txn_state_t state_next;

    logic [1:0] cond_cnt;    // Ticks inside the current START/STOP step
    logic       cond_state;
    logic       bit_state;   // Address, data or ACK slot
    logic       step_end;
    logic       bit_end;
    logic       scl_high;
    logic       rd_txn;
    logic       wr_txn;
    logic       ack_ok;      // SDA was low in the last ACK slot
    logic       err_set;
    logic       done_d;
    logic       scl_d;
    logic       sda_d;
    logic       oe_d;

    assign bit_state = (state == i2c_pkg::addr_bit) || (state == i2c_pkg::addr_ack) ||
                       (state == i2c_pkg::data_bit) || (state == i2c_pkg::data_ack);
    assign cond_state = (state != i2c_pkg::idle) && !bit_state;

    assign step_end = tk.tick && (cond_cnt == 2'(i2c_pkg::PHASES_PER_COND - 1));
    assign bit_end  = tk.tick && (tk.phase == i2c_pkg::high_2);
    assign scl_high = (tk.phase == i2c_pkg::high_1) || (tk.phase == i2c_pkg::high_2);
    assign rd_txn   = (sh.is_read == i2c_pkg::I2C_READ);
    assign wr_txn   = (sh.is_read == i2c_pkg::I2C_WRITE);

    assign busy         = (state != i2c_pkg::idle);
    assign tk.run       = busy;
    assign tk.phase_clr = cond_state;

    assign sh.capture     = tk.sample && (state == i2c_pkg::data_bit) && rd_txn;
    assign sh.capture_val = sda_in;

    // ======================================================================
    // Next state and shifter commands
    // ======================================================================
    always_comb begin
        state_next   = state;
        sh.load      = 1'b0;
        sh.next_byte = 1'b0;
        sh.advance   = 1'b0;
        err_set      = 1'b0;
        done_d       = 1'b0;

        case (state)
            i2c_pkg::idle: begin
                if (start) begin
                    state_next = i2c_pkg::start_1;
                    sh.load    = 1'b1;
                end
            end
            i2c_pkg::start_1: if (step_end) state_next = i2c_pkg::start_2;
            i2c_pkg::start_2: if (step_end) state_next = i2c_pkg::start_3;
            i2c_pkg::start_3: if (step_end) state_next = i2c_pkg::addr_bit;
            i2c_pkg::addr_bit: begin
                if (bit_end) begin
                    if (sh.last_bit) state_next = i2c_pkg::addr_ack;
                    else             sh.advance = 1'b1;
                end
            end
            i2c_pkg::addr_ack: begin
                if (bit_end) begin
                    if (ack_ok) begin
                        state_next   = i2c_pkg::data_bit;
                        sh.next_byte = 1'b1;
                    end else begin
                        state_next = i2c_pkg::stop_1;  // Nobody answered
                        err_set    = 1'b1;
                    end
                end
            end
            i2c_pkg::data_bit: begin
                if (bit_end) begin
                    if (sh.last_bit) state_next = i2c_pkg::data_ack;
                    else             sh.advance = 1'b1;
                end
            end
            i2c_pkg::data_ack: begin
                if (bit_end) begin
                    state_next = i2c_pkg::stop_1;
                    err_set    = wr_txn && !ack_ok;
                end
            end
            i2c_pkg::stop_1: if (step_end) state_next = i2c_pkg::stop_2;
            i2c_pkg::stop_2: if (step_end) state_next = i2c_pkg::stop_3;
            i2c_pkg::stop_3: begin
                if (step_end) begin
                    state_next = i2c_pkg::idle;
                    done_d     = 1'b1;
                end
            end
            default: state_next = i2c_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= i2c_pkg::idle;
            cond_cnt  <= '0;
            ack_ok    <= 1'b0;
            ack_error <= 1'b0;
            done      <= 1'b0;
        end else begin
            state <= state_next;
            done  <= done_d;
            if (!cond_state || step_end) begin
                cond_cnt <= '0;
            end else if (tk.tick) begin
                cond_cnt <= cond_cnt + 2'd1;
            end
            // Read data ACK slot is ours, nothing to record there
            if (tk.sample && ((state == i2c_pkg::addr_ack) ||
                              ((state == i2c_pkg::data_ack) && wr_txn))) begin
                ack_ok <= ~sda_in;
            end
            if ((state == i2c_pkg::idle) && start) begin
                ack_error <= 1'b0;
            end else if (err_set) begin
                ack_error <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Bus levels
    // ======================================================================
    always_comb begin
        scl_d = 1'b1;  // Idle bus, both lines high
        sda_d = 1'b1;
        oe_d  = 1'b1;
        case (state)
            i2c_pkg::start_2, i2c_pkg::stop_2: sda_d = 1'b0;
            i2c_pkg::start_3, i2c_pkg::stop_1: begin
                scl_d = 1'b0;
                sda_d = 1'b0;
            end
            i2c_pkg::addr_bit: begin
                scl_d = scl_high;
                sda_d = sh.tx_bit;
            end
            i2c_pkg::addr_ack: begin
                scl_d = scl_high;
                oe_d  = 1'b0;    // Slave ACK
            end
            i2c_pkg::data_bit: begin
                scl_d = scl_high;
                sda_d = rd_txn | sh.tx_bit;
                oe_d  = wr_txn;
            end
            i2c_pkg::data_ack: begin
                scl_d = scl_high;
                oe_d  = rd_txn;  // NACK after the single read byte
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else begin
            scl     <= scl_d;
            sda_out <= sda_d;
            sda_oe  <= oe_d;
        end
    end

    a_done_after_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(busy && done)
    );

    // Data may only move while SCL is low, else the slave sees START or STOP
    a_sda_stable_scl_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        (scl_d && bit_state && $past(scl_d) && $past(bit_state)) |-> $stable(sda_d)
    );

endmodule

`default_nettype wire

//--- tb.f
i2c_pkg.sv
i2c_tick_if.sv
i2c_shift_if.sv
i2c_phase_timer.sv
i2c_byte_shifter.sv
i2c_txn_fsm.sv
i2c_master.sv
tb_i2c_slave.sv
tb_i2c_master.sv

//--- tb_i2c_master.sv
`default_nettype none

module tb_i2c_master;
    timeunit 1ns;
    timeprecision 1ps;

    // 3 START steps, 18 bit slots and 3 STOP steps, or 9 bit slots on a NACK
    localparam int TXN_CLKS  = (3 * 2 + 18 * 4 + 3 * 2) * i2c_pkg::CLK_PER_PHASE;
    localparam int NACK_CLKS = (3 * 2 + 9 * 4 + 3 * 2) * i2c_pkg::CLK_PER_PHASE;
    localparam int TIMEOUT   = 30000;
    localparam logic [6:0] SLAVE_ADDR = 7'h55;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       rw_bit;
    logic [6:0] slave_addr;
    logic [7:0] tx_data;
    logic [7:0] rx_data;
    logic       busy;
    logic       done;
    logic       ack_error;
    logic       scl;
    wire        sda;
    logic [7:0] slv_rd_byte;
    logic [7:0] slv_wr_byte;
    logic       slv_nack;

    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          n_tests;
    int          cyc;
    int          start_cyc;
    int          latency;
    int          exp_latency;
    int          extra_dones;
    logic        exp_ack_error;
    logic [7:0]  exp_wr_byte;
    logic [7:0]  exp_rx;
    logic        chk_reset;
    logic        chk_done;
    logic        chk_wr;
    logic        chk_rd;
    logic        chk_extra;
    logic        chk_busy;

    i2c_master dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rw_bit     (rw_bit),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error),
        .sda        (sda),
        .scl        (scl)
    );

    tb_i2c_slave u_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl         (scl),
        .sda         (sda),
        .rd_byte     (slv_rd_byte),
        .wr_byte     (slv_wr_byte),
        .master_nack (slv_nack)
    );

    pullup (sda);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic clear_checks();
        chk_reset = 1'b0;
        chk_done  = 1'b0;
        chk_wr    = 1'b0;
        chk_rd    = 1'b0;
        chk_extra = 1'b0;
        chk_busy  = 1'b0;
    endtask

    task automatic report_mismatch(input string what, input int exp_v, input int act_v);
        $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp_v, act_v);
        errors++;
    endtask

    task automatic report_test(input string name, input int err0);
        n_tests++;
        if (errors == err0) $display("test %s: ok", name);
        else                $display("test %s: %0d error(s)", name, errors - err0);
    endtask

    // One transfer, expectations follow from the address and R/W rules
    task automatic run_test(input string name, input logic rw, input logic [6:0] addr,
                            input logic [7:0] data, input logic restart);
        int   n;
        int   err0;
        logic hit;

        err0          = errors;
        test_name     = name;
        hit           = (addr == SLAVE_ADDR);
        exp_latency   = hit ? TXN_CLKS : NACK_CLKS;
        exp_ack_error = !hit;
        exp_rx        = slv_rd_byte;
        if (hit && rw == i2c_pkg::I2C_WRITE) exp_wr_byte = data;

        @(negedge clk);
        rw_bit     = rw;
        slave_addr = addr;
        tx_data    = data;
        start      = 1'b1;
        start_cyc  = cyc + 1;              // Edge that accepts start
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            chk_busy = !done;              // Held until the done pulse
            start = restart && (n == 100); // Lands mid-transfer
            if (start) tx_data = ~data;
        end
        chk_busy = 1'b0;
        latency = cyc - start_cyc;

        if (!done) begin
            $display("test %s: no done pulse within %0d cycles", name, TIMEOUT);
            errors++;
        end else begin
            chk_done = 1'b1;
            chk_wr   = (rw == i2c_pkg::I2C_WRITE);
            chk_rd   = (rw == i2c_pkg::I2C_READ) && hit;
            @(negedge clk);
            clear_checks();
            if (restart) begin
                extra_dones = 0;
                repeat (TXN_CLKS) begin
                    @(negedge clk);
                    if (done) extra_dones++;
                end
                chk_extra = 1'b1;
                @(negedge clk);
                clear_checks();
            end
        end
        report_test(name, err0);
    endtask

    // ======================================================================
    // Checks
    // ======================================================================
    a_reset_levels : assert property (@(posedge clk)
        chk_reset |-> ({scl, sda, busy, done, ack_error} === 5'b11000))
        else report_mismatch("scl/sda/busy/done/ack_error", 5'b11000,
                             $sampled({scl, sda, busy, done, ack_error}));
    a_latency : assert property (@(posedge clk) chk_done |-> latency == exp_latency)
        else report_mismatch("latency", exp_latency, $sampled(latency));
    a_ack_error : assert property (@(posedge clk) chk_done |-> ack_error == exp_ack_error)
        else report_mismatch("ack_error", exp_ack_error, $sampled(ack_error));
    a_wr_byte : assert property (@(posedge clk) chk_wr |-> slv_wr_byte == exp_wr_byte)
        else report_mismatch("slave byte", exp_wr_byte, $sampled(slv_wr_byte));
    a_rx_data : assert property (@(posedge clk) chk_rd |-> rx_data == exp_rx)
        else report_mismatch("rx_data", exp_rx, $sampled(rx_data));
    a_read_nack : assert property (@(posedge clk) chk_rd |-> slv_nack)
        else report_mismatch("ninth bit", 1, $sampled(slv_nack));
    a_no_extra_done : assert property (@(posedge clk) chk_extra |-> extra_dones == 0)
        else report_mismatch("extra done pulses", 0, $sampled(extra_dones));
    a_busy_held : assert property (@(posedge clk) chk_busy |-> busy)
        else report_mismatch("busy", 1, $sampled(busy));
    a_busy_falls_with_done : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done)
        else begin
            $display("busy fell without a done pulse in %s", test_name);
            errors++;
        end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        logic [7:0] b;
        logic [6:0] bad_addr;

        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        rw_bit      = i2c_pkg::I2C_WRITE;
        slave_addr  = '0;
        tx_data     = '0;
        slv_rd_byte = '0;
        lfsr        = 32'hd98c;
        errors      = 0;
        n_tests     = 0;
        cyc         = 0;
        latency     = 0;
        exp_latency = 0;
        extra_dones = 0;
        exp_ack_error = 1'b0;
        exp_wr_byte = '0;
        exp_rx      = '0;
        test_name   = "reset";
        clear_checks();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        chk_reset = 1'b1;
        @(negedge clk);
        clear_checks();
        report_test("reset", 0);

        rand_byte(b);
        run_test("write", i2c_pkg::I2C_WRITE, SLAVE_ADDR, b, 1'b0);

        rand_byte(b);
        slv_rd_byte = b;
        run_test("read", i2c_pkg::I2C_READ, SLAVE_ADDR, 8'h00, 1'b0);

        rand_byte(b);
        bad_addr = b[6:0] ^ {6'd0, (b[6:0] == SLAVE_ADDR)};
        rand_byte(b);
        run_test("wrong_addr", i2c_pkg::I2C_WRITE, bad_addr, b, 1'b0);

        rand_byte(b);
        run_test("start_while_busy", i2c_pkg::I2C_WRITE, SLAVE_ADDR, b, 1'b1);

        $display("%0d tests, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_i2c_slave.sv
`default_nettype none

module tb_i2c_slave (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scl,
    inout  wire        sda,
    input  logic [7:0] rd_byte,      // Served on a read
    output logic [7:0] wr_byte,      // Last byte written to us
    output logic       master_nack   // Master's ninth bit after a read byte
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OWN_ADDR = 7'h55;

    logic       scl_q;
    logic       sda_q;
    logic       drive_low;
    logic       addressed;
    logic       is_rd;
    logic       data_phase;   // Second byte of the transfer
    logic [3:0] bits;         // SCL rises seen in this byte
    logic [7:0] shreg;
    logic [7:0] rd_sr;

    // Let go at once on SCL fall, the master moves SDA on that same edge
    assign sda = (drive_low && !(scl_q && !scl)) ? 1'b0 : 1'bz;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            drive_low   <= 1'b0;
            addressed   <= 1'b0;
            is_rd       <= 1'b0;
            data_phase  <= 1'b0;
            bits        <= '0;
            shreg       <= '0;
            rd_sr       <= '0;
            wr_byte     <= '0;
            master_nack <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) begin          // START
                bits        <= '0;
                data_phase  <= 1'b0;
                addressed   <= 1'b0;
                drive_low   <= 1'b0;
                master_nack <= 1'b0;
            end else if (scl_q && scl && !sda_q && sda) begin // STOP
                bits      <= '0;
                addressed <= 1'b0;
                drive_low <= 1'b0;
            end else if (!scl_q && scl) begin
                if (bits < 4'd8) shreg <= {shreg[6:0], sda};
                else if (data_phase && is_rd) master_nack <= sda;
                bits <= bits + 4'd1;
            end else if (scl_q && !scl) begin
                if (bits == 4'd8) begin
                    if (!data_phase) begin
                        addressed <= (shreg[7:1] == OWN_ADDR);
                        is_rd     <= shreg[0];
                        drive_low <= (shreg[7:1] == OWN_ADDR);  // Address ACK
                    end else if (addressed && !is_rd) begin
                        wr_byte   <= shreg;
                        drive_low <= 1'b1;                      // Data ACK
                    end else begin
                        drive_low <= 1'b0;
                    end
                end else if (bits == 4'd9) begin
                    bits       <= '0;
                    data_phase <= 1'b1;
                    rd_sr      <= rd_byte;
                    drive_low  <= !data_phase && addressed && is_rd && !rd_byte[7];
                end else if (data_phase && addressed && is_rd && bits != 4'd0) begin
                    drive_low <= !rd_sr[3'd7 - bits[2:0]];      // MSB first
                end
            end
        end
    end

endmodule

`default_nettype wire
